// File: tpu.f
tpu_pkg.sv
mac_cell.sv
sys_arr.sv
mem_arr.sv
weight_fifo.sv
tpu_control.sv
accum_table.sv
tpu_top.sv
tpu_asserts.sv
tb_tpu.sv

// File: Makefile
VERILATOR := verilator
TOP       := tb_tpu
FILELIST  := tpu.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)
SIM_BIN   := ./$(OBJ_DIR)/V$(TOP)
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)
	$(SIM_BIN) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_tpu.sv
/* random commands from a fixed seed against a reference model of memories, tile and table
   host writes only between commands; every wait is bounded by TIMEOUT cycles */
`timescale 1ns/1ns

module tb_tpu import tpu_pkg::*; ();

    localparam int TIMEOUT = 200;           // cycles allowed per command

    logic       clk;
    logic       rst;
    lane_mask_t in_wr_en;
    mem_addr_t  in_wr_addr;
    data_vec_t  in_wr_data;
    lane_mask_t w_wr_en;
    mem_addr_t  w_wr_addr;
    data_vec_t  w_wr_data;
    logic       load_weights;
    mem_addr_t  w_base;
    logic       start;
    mem_addr_t  in_base;
    row_cnt_t   num_rows;
    acc_addr_t  acc_base;
    logic       accumulate;
    logic       busy;
    logic       done;
    logic       acc_rd_en;
    acc_addr_t  acc_rd_addr;
    acc_vec_t   acc_rd_data;

    // reference model
    data_t            in_m  [MEM_DEPTH][ARR_N];
    data_t            w_m   [MEM_DEPTH][ARR_N];
    data_t            tile  [ARR_N][ARR_N];     // [pe row][lane]
    logic [ACC_W-1:0] acc_m [ACC_DEPTH][ARR_N]; // signed contents, kept raw
    int errors   = 0;
    int timeouts = 0;
    int cmd_cnt  = 0;                           // accepted commands
    int done_cnt = 0;

    tpu_top tpu_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        if (!rst && done) begin
            done_cnt++;                         // extra pulses show up at the end
        end
    end

    // ========================================
    // host side
    // ========================================
    task automatic write_row(input bit to_w, input lane_mask_t mask, input mem_addr_t addr,
                             input data_vec_t data);
        @(posedge clk);
        if (to_w) begin
            w_wr_en   <= mask;
            w_wr_addr <= addr;
            w_wr_data <= data;
        end else begin
            in_wr_en   <= mask;
            in_wr_addr <= addr;
            in_wr_data <= data;
        end
        for (int k = 0; k < ARR_N; k++) begin
            if (mask[k] && to_w) begin
                w_m[addr][k] = data[k*DATA_W +: DATA_W];
            end else if (mask[k]) begin
                in_m[addr][k] = data[k*DATA_W +: DATA_W];
            end                                 // masked banks keep old bytes
        end
        @(posedge clk);
        w_wr_en  <= '0;
        in_wr_en <= '0;
    endtask

    // waits for done; with noise, throws in pulses only while a command runs
    task automatic wait_done(input bit noise);
        int cyc;
        bit seen;
        cyc  = 0;
        seen = 0;
        while (!seen && cyc < TIMEOUT) begin
            @(posedge clk);
            load_weights <= 1'b0;
            start        <= 1'b0;
            if (done) begin
                seen = 1;
            end else if (noise && busy) begin
                if ($urandom_range(3, 0) == 0) begin
                    load_weights <= 1'b1;
                    w_base       <= mem_addr_t'($urandom()); // other fields, same outcome
                end
                if ($urandom_range(3, 0) == 0) begin
                    start      <= 1'b1;
                    in_base    <= mem_addr_t'($urandom());
                    num_rows   <= row_cnt_t'($urandom_range(16, 1));
                    acc_base   <= acc_addr_t'($urandom());
                    accumulate <= 1'($urandom());
                end
            end
            cyc++;
        end
        if (!seen) begin
            timeouts++;
            $display("timeout: no done within %0d cycles of command %0d", TIMEOUT, cmd_cnt);
        end
    endtask

    task automatic load_tile(input mem_addr_t base, input bit noise);
        @(posedge clk);
        load_weights <= 1'b1;
        w_base       <= base;
        cmd_cnt++;
        wait_done(noise);
        for (int r = 0; r < ARR_N; r++) begin
            for (int c = 0; c < ARR_N; c++) begin
                tile[r][c] = w_m[(int'(base) + r) % MEM_DEPTH][c];  // pe row r <- word base+r
            end
        end
    endtask

    task automatic run_rows(input mem_addr_t in_b, input row_cnt_t n, input acc_addr_t acc_b,
                            input bit accum, input bit noise);
        int s;
        int row;
        int a;
        @(posedge clk);
        start      <= 1'b1;
        in_base    <= in_b;
        num_rows   <= n;
        acc_base   <= acc_b;
        accumulate <= accum;
        cmd_cnt++;
        wait_done(noise);
        for (int i = 0; i < int'(n); i++) begin
            row = (int'(in_b) + i) % MEM_DEPTH;
            a   = (int'(acc_b) + i) % ACC_DEPTH;
            for (int c = 0; c < ARR_N; c++) begin
                s = 0;
                for (int r = 0; r < ARR_N; r++) begin
                    s += int'(in_m[row][r]) * int'(tile[r][c]);
                end
                if (accum) begin
                    acc_m[a][c] = acc_m[a][c] + s[ACC_W-1:0];   // 24-bit wrap
                end else begin
                    acc_m[a][c] = s[ACC_W-1:0];
                end
            end
        end
    endtask

    // reads every entry, read data is one cycle behind the enable
    task automatic check_table();
        logic [ACC_W-1:0] exp_v;
        logic [ACC_W-1:0] got_v;
        for (int a = 0; a < ACC_DEPTH; a++) begin
            @(posedge clk);
            acc_rd_en   <= 1'b1;
            acc_rd_addr <= acc_addr_t'(a);
            @(posedge clk);
            acc_rd_en <= 1'b0;
            @(posedge clk);
            for (int c = 0; c < ARR_N; c++) begin
                exp_v = acc_m[a][c][ACC_W-1] ? '0 : acc_m[a][c];  // relu
                got_v = acc_rd_data[c*ACC_W +: ACC_W];
                if (got_v !== exp_v) begin
                    errors++;
                    $display("CHECK FAILED acc_rd_data lane %0d entry %h: expected %h, got %h",
                             c, a, exp_v, got_v);
                end
            end
        end
    endtask

    // ========================================
    // test sequence
    // ========================================
    initial begin
        int        x;
        data_vec_t v;
        data_vec_t y;
        mem_addr_t wb;
        void'($urandom(54055));
        rst          = 1'b1;
        in_wr_en     = '0;
        in_wr_addr   = '0;
        in_wr_data   = '0;
        w_wr_en      = '0;
        w_wr_addr    = '0;
        w_wr_data    = '0;
        load_weights = 1'b0;
        w_base       = '0;
        start        = 1'b0;
        in_base      = '0;
        num_rows     = row_cnt_t'(1);
        acc_base     = '0;
        accumulate   = 1'b0;
        acc_rd_en    = 1'b0;
        acc_rd_addr  = '0;
        for (int a = 0; a < ACC_DEPTH; a++) begin
            for (int c = 0; c < ARR_N; c++) begin
                acc_m[a][c] = '0;               // reset clears the table
            end
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // random product, overwrite
        for (int a = 0; a < MEM_DEPTH; a++) begin
            write_row(1'b1, '1, mem_addr_t'(a), data_vec_t'($urandom()));
            write_row(1'b0, '1, mem_addr_t'(a), data_vec_t'($urandom()));
        end
        wb = mem_addr_t'($urandom());
        load_tile(wb, 1'b0);
        run_rows(mem_addr_t'($urandom()), row_cnt_t'($urandom_range(16, 1)),
                 acc_addr_t'($urandom()), 1'b0, 1'b0);
        check_table();

        // negative lanes, then half the opposite rows on top
        for (int a = 0; a < 4; a++) begin
            for (int k = 0; k < ARR_N; k++) begin
                x = int'($urandom_range(127, 0)) - 64;
                v[k*DATA_W +: DATA_W] = data_t'(x);
                y[k*DATA_W +: DATA_W] = data_t'(-(x / 2));
            end
            write_row(1'b0, '1, mem_addr_t'(a), v);
            write_row(1'b0, '1, mem_addr_t'(a + 4), y);
        end
        run_rows(mem_addr_t'(0), row_cnt_t'(4), acc_addr_t'(8), 1'b0, 1'b0);
        check_table();
        run_rows(mem_addr_t'(4), row_cnt_t'(4), acc_addr_t'(8), 1'b1, 1'b0);
        check_table();

        // two commands into one acc_base
        run_rows(mem_addr_t'($urandom()), row_cnt_t'($urandom_range(16, 1)),
                 acc_addr_t'(14), 1'b0, 1'b0);
        run_rows(mem_addr_t'($urandom()), row_cnt_t'($urandom_range(16, 1)),
                 acc_addr_t'(14), 1'b1, 1'b0);
        check_table();

        // new tile from another base
        load_tile(wb + mem_addr_t'(5), 1'b0);
        run_rows(mem_addr_t'($urandom()), row_cnt_t'($urandom_range(16, 1)),
                 acc_addr_t'($urandom()), 1'b0, 1'b0);
        check_table();

        // stray pulses while busy
        repeat (3) begin
            load_tile(mem_addr_t'($urandom()), 1'b1);
            run_rows(mem_addr_t'($urandom()), row_cnt_t'($urandom_range(16, 1)),
                     acc_addr_t'($urandom()), 1'($urandom()), 1'b1);
        end
        check_table();

        // partial-lane writes
        repeat (10) begin
            write_row(1'($urandom()), lane_mask_t'($urandom()), mem_addr_t'($urandom()),
                      data_vec_t'($urandom()));
        end
        load_tile(mem_addr_t'($urandom()), 1'b0);
        run_rows(mem_addr_t'($urandom()), row_cnt_t'(16), acc_addr_t'($urandom()),
                 1'b0, 1'b0);
        check_table();

        repeat (4) @(posedge clk);
        if (done_cnt != cmd_cnt) begin
            errors++;
            $display("saw %0d done pulses for %0d accepted commands", done_cnt, cmd_cnt);
        end
        $display("errors: %0d check failures, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: tpu_asserts.sv
/* command output checks, bound into every tpu_top instance
   assumes rst is held at the start of the run */
`timescale 1ns/1ns

module tpu_asserts (
    input logic clk,
    input logic rst,
    input logic busy,
    input logic done
);

    // ========================================
    // control outputs
    // ========================================
    a_rst_idle: assert property (@(posedge clk) rst |=> (!busy && !done))
        else $error("busy or done high after a reset cycle");

    a_done_busy: assert property (@(posedge clk) disable iff (rst) done |-> busy)
        else $error("done pulsed while not busy");      // done is the last busy cycle

    a_done_one: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done high on two cycles in a row");

    a_busy_fall: assert property (@(posedge clk) disable iff (rst) (busy && !done) |=> busy)
        else $error("busy fell without done");          // only done ends a command

endmodule

bind tpu_top tpu_asserts tpu_asserts_i (
    .clk  (clk),
    .rst  (rst),
    .busy (busy),
    .done (done)
);

// File: tpu_top.sv
/* matrix engine top; host writes memories only while busy is low,
   commands are one-cycle pulses and done pulses once per accepted command */
`timescale 1ns/1ns

module tpu_top import tpu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  lane_mask_t in_wr_en,
    input  mem_addr_t  in_wr_addr,
    input  data_vec_t  in_wr_data,
    input  lane_mask_t w_wr_en,
    input  mem_addr_t  w_wr_addr,
    input  data_vec_t  w_wr_data,
    input  logic       load_weights,
    input  mem_addr_t  w_base,
    input  logic       start,
    input  mem_addr_t  in_base,
    input  row_cnt_t   num_rows,
    input  acc_addr_t  acc_base,
    input  logic       accumulate,
    output logic       busy,
    output logic       done,
    input  logic       acc_rd_en,
    input  acc_addr_t  acc_rd_addr,
    output acc_vec_t   acc_rd_data
);

    logic      w_rd_en;
    mem_addr_t w_rd_addr;
    data_vec_t w_rd_data;       // weight memory -> fifo
    logic      fill_en;
    logic      drain_en;
    logic      weight_write;
    data_vec_t fifo_out;        // fifo bottom -> array top
    logic      in_rd_en;
    mem_addr_t in_rd_addr;
    data_vec_t in_rd_data;      // input memory -> array
    logic      arr_valid;
    acc_vec_t  arr_result;
    logic      result_valid;
    logic      acc_wr_en;
    acc_addr_t acc_wr_addr;
    logic      acc_accum;

    // ========================================
    // memories
    // ========================================
    mem_arr in_mem (
        .clk     (clk),
        .wr_en   (in_wr_en),    // host
        .wr_addr (in_wr_addr),
        .wr_data (in_wr_data),
        .rd_en   (in_rd_en),    // control
        .rd_addr (in_rd_addr),
        .rd_data (in_rd_data)
    );

    mem_arr w_mem (
        .clk     (clk),
        .wr_en   (w_wr_en),
        .wr_addr (w_wr_addr),
        .wr_data (w_wr_data),
        .rd_en   (w_rd_en),
        .rd_addr (w_rd_addr),
        .rd_data (w_rd_data)
    );

    weight_fifo weight_fifo_i (
        .clk   (clk),
        .rst   (rst),
        .en    (fill_en | drain_en),
        .w_in  (w_rd_data),
        .w_out (fifo_out)
    );

    // ========================================
    // array and control
    // ========================================
    sys_arr sys_arr_i (
        .clk          (clk),
        .rst          (rst),
        .data_in      (in_rd_data),
        .w_in         (fifo_out),
        .w_shift      (weight_write),
        .in_valid     (arr_valid),
        .result       (arr_result),
        .result_valid (result_valid)
    );

    tpu_control tpu_control_i (
        .clk          (clk),
        .rst          (rst),
        .load_weights (load_weights),
        .w_base       (w_base),
        .start        (start),
        .in_base      (in_base),
        .num_rows     (num_rows),
        .acc_base     (acc_base),
        .accumulate   (accumulate),
        .result_valid (result_valid),
        .w_rd_en      (w_rd_en),
        .w_rd_addr    (w_rd_addr),
        .fill_en      (fill_en),
        .drain_en     (drain_en),
        .weight_write (weight_write),
        .in_rd_en     (in_rd_en),
        .in_rd_addr   (in_rd_addr),
        .arr_valid    (arr_valid),
        .acc_wr_en    (acc_wr_en),
        .acc_wr_addr  (acc_wr_addr),
        .acc_accum    (acc_accum),
        .busy         (busy),
        .done         (done)
    );

    accum_table accum_table_i (
        .clk        (clk),
        .rst        (rst),
        .wr_en      (acc_wr_en),
        .wr_addr    (acc_wr_addr),
        .wr_data    (arr_result),
        .accumulate (acc_accum),
        .rd_en      (acc_rd_en),     // host read port
        .rd_addr    (acc_rd_addr),
        .rd_data    (acc_rd_data)
    );

endmodule

// File: accum_table.sv
/* result rows, written whole; accumulate adds per lane with 24-bit wrap
   reads return the ReLU of the entry one cycle later, the entry keeps its sign */
`timescale 1ns/1ns

module accum_table import tpu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      wr_en,
    input  acc_addr_t wr_addr,
    input  acc_vec_t  wr_data,
    input  logic      accumulate,   // add to the entry instead of overwrite
    input  logic      rd_en,
    input  acc_addr_t rd_addr,
    output acc_vec_t  rd_data
);

    acc_vec_t tbl_q [ACC_DEPTH];

    // negative lanes read as zero
    function automatic acc_vec_t relu(input acc_vec_t row);
        acc_vec_t res;
        for (int k = 0; k < ARR_N; k++) begin
            res[k*ACC_W +: ACC_W] = row[k*ACC_W + ACC_W - 1] ? '0 : row[k*ACC_W +: ACC_W];
        end
        return res;
    endfunction

    // ========================================
    // write side
    // ========================================
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ACC_DEPTH; i++) begin
                tbl_q[i] <= '0;
            end
        end else if (wr_en) begin
            for (int k = 0; k < ARR_N; k++) begin
                if (accumulate) begin
                    tbl_q[wr_addr][k*ACC_W +: ACC_W] <=
                        tbl_q[wr_addr][k*ACC_W +: ACC_W] + wr_data[k*ACC_W +: ACC_W];
                end else begin
                    tbl_q[wr_addr][k*ACC_W +: ACC_W] <= wr_data[k*ACC_W +: ACC_W];
                end
            end
        end
    end

    // ========================================
    // read side
    // ========================================
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= relu(tbl_q[rd_addr]); // old data on a same-address write
        end
    end

endmodule

// File: tpu_control.sv
/* command sequencer; commands are taken only in IDLE and ignored while busy
   num_rows must be 1..16; load_weights wins when both pulses come together */
`timescale 1ns/1ns

module tpu_control import tpu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      load_weights,
    input  mem_addr_t w_base,
    input  logic      start,
    input  mem_addr_t in_base,
    input  row_cnt_t  num_rows,
    input  acc_addr_t acc_base,
    input  logic      accumulate,
    input  logic      result_valid,
    output logic      w_rd_en,
    output mem_addr_t w_rd_addr,
    output logic      fill_en,
    output logic      drain_en,
    output logic      weight_write,
    output logic      in_rd_en,
    output mem_addr_t in_rd_addr,
    output logic      arr_valid,
    output logic      acc_wr_en,
    output acc_addr_t acc_wr_addr,
    output logic      acc_accum,
    output logic      busy,
    output logic      done
);

    ctrl_state_t state_q;
    row_cnt_t    cnt_q;         // reads or shifts in this phase
    row_cnt_t    res_cnt_q;     // results written so far
    mem_addr_t   w_base_q;
    mem_addr_t   in_base_q;
    row_cnt_t    rows_q;
    acc_addr_t   acc_base_q;
    logic        accum_q;
    logic        last_rd;
    logic        last_res;
    logic        drain_end;

    // ========================================
    // decodes
    // ========================================
    assign last_rd   = cnt_q == rows_q - 1'b1;
    assign last_res  = result_valid && (res_cnt_q == rows_q - 1'b1);
    assign drain_end = (state_q == DRAIN) && (cnt_q == row_cnt_t'(ARR_N - 1));

    // tile rows read top address first, see weight_fifo
    assign w_rd_en   = (state_q == FILL) && (cnt_q < row_cnt_t'(ARR_N));
    assign w_rd_addr = w_base_q + mem_addr_t'(ARR_N - 1) - mem_addr_t'(cnt_q);

    assign drain_en     = state_q == DRAIN;
    assign weight_write = state_q == DRAIN;    // array shifts with the fifo

    assign in_rd_en   = state_q == STREAM;
    assign in_rd_addr = in_base_q + mem_addr_t'(cnt_q);

    assign acc_wr_en   = result_valid;
    assign acc_wr_addr = acc_base_q + acc_addr_t'(res_cnt_q); // wraps mod 16
    assign acc_accum   = accum_q;

    assign busy = state_q != IDLE;
    assign done = drain_end || ((state_q == FLUSH) && last_res);

    // ========================================
    // state machine
    // ========================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= IDLE;
            cnt_q     <= '0;
            res_cnt_q <= '0;
            fill_en   <= 1'b0;
            arr_valid <= 1'b0;
        end else begin
            fill_en   <= w_rd_en;              // one cycle of read latency
            arr_valid <= in_rd_en;
            if (result_valid) begin
                res_cnt_q <= res_cnt_q + 1'b1;
            end
            cnt_q <= cnt_q + 1'b1;
            case (state_q)
                IDLE: begin
                    cnt_q <= '0;
                    if (load_weights) begin
                        state_q <= FILL;
                    end else if (start) begin
                        state_q   <= STREAM;
                        res_cnt_q <= '0;
                    end
                end
                FILL: begin
                    if (cnt_q == row_cnt_t'(ARR_N)) begin   // last fill shift
                        state_q <= DRAIN;
                        cnt_q   <= '0;
                    end
                end
                DRAIN: begin
                    if (drain_end) begin
                        state_q <= IDLE;
                    end
                end
                STREAM: begin
                    if (last_rd) begin
                        state_q <= FLUSH;
                    end
                end
                FLUSH: begin
                    if (last_res) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // command fields follow the inputs until a command is taken
    always_ff @(posedge clk) begin
        if (state_q == IDLE) begin
            w_base_q   <= w_base;
            in_base_q  <= in_base;
            rows_q     <= num_rows;
            acc_base_q <= acc_base;
            accum_q    <= accumulate;
        end
    end

endmodule

// File: weight_fifo.sv
/* ARR_N column shift registers, ARR_N deep; the controller reads memory
   rows last row first so that row 0 of the tile ends in the top PE row */
`timescale 1ns/1ns

module weight_fifo import tpu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      en,       // fill or drain shift
    input  data_vec_t w_in,     // memory row in at the top
    output data_vec_t w_out     // bottom row to the array
);

    data_vec_t stage_q [ARR_N]; // [0] top, [ARR_N-1] bottom

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < ARR_N; k++) begin
                stage_q[k] <= '0;
            end
        end else if (en) begin
            stage_q[0] <= w_in;
            for (int k = 1; k < ARR_N; k++) begin
                stage_q[k] <= stage_q[k-1];     // every column moves down
            end
        end
    end

    assign w_out = stage_q[ARR_N-1];

endmodule

// File: mem_arr.sv
/* ARR_N byte banks behind one address; read data is registered and holds
   while rd_en is low; a read of the address being written returns old data */
`timescale 1ns/1ns

module mem_arr import tpu_pkg::*; (
    input  logic       clk,
    input  lane_mask_t wr_en,       // one bit per bank
    input  mem_addr_t  wr_addr,
    input  data_vec_t  wr_data,
    input  logic       rd_en,
    input  mem_addr_t  rd_addr,
    output data_vec_t  rd_data
);

    data_t bank_q [ARR_N][MEM_DEPTH];

    always_ff @(posedge clk) begin
        for (int k = 0; k < ARR_N; k++) begin
            if (wr_en[k]) begin
                bank_q[k][wr_addr] <= wr_data[k*DATA_W +: DATA_W]; // masked banks keep data
            end
            if (rd_en) begin
                rd_data[k*DATA_W +: DATA_W] <= bank_q[k][rd_addr];
            end
        end
    end

endmodule

// File: sys_arr.sv
/* weight-stationary grid; a row given with in_valid leaves ARR_LAT cycles later
   as one vector; rows may follow back to back, weights must not move meanwhile */
`timescale 1ns/1ns

module sys_arr import tpu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  data_vec_t data_in,
    input  data_vec_t w_in,         // top row of weights
    input  logic      w_shift,
    input  logic      in_valid,
    output acc_vec_t  result,
    output logic      result_valid
);

    data_t skew_d [ARR_N];              // lane r delayed by r cycles
    data_t dat_h  [ARR_N][ARR_N+1];     // data flowing east
    data_t w_v    [ARR_N+1][ARR_N];     // weights flowing south
    acc_t  sum_v  [ARR_N+1][ARR_N];     // partial sums flowing south
    logic [ARR_LAT-1:0] vld_q;          // valid follows the data

    // ========================================
    // input skew
    // ========================================
    for (genvar r = 0; r < ARR_N; r++) begin : g_skew
        if (r == 0) begin : g_pass
            assign skew_d[r] = data_in[r*DATA_W +: DATA_W];
        end else begin : g_dly
            data_t dly_q [r];
            always_ff @(posedge clk) begin
                dly_q[0] <= data_in[r*DATA_W +: DATA_W];
                for (int k = 1; k < r; k++) begin
                    dly_q[k] <= dly_q[k-1];
                end
            end
            assign skew_d[r] = dly_q[r-1];
        end
        assign dat_h[r][0] = skew_d[r];
    end

    // ========================================
    // grid of cells
    // ========================================
    for (genvar r = 0; r < ARR_N; r++) begin : g_row
        for (genvar c = 0; c < ARR_N; c++) begin : g_col
            mac_cell u_pe (
                .clk      (clk),
                .rst      (rst),
                .data_in  (dat_h[r][c]),
                .data_out (dat_h[r][c+1]),
                .w_in     (w_v[r][c]),
                .w_out    (w_v[r+1][c]),
                .w_shift  (w_shift),
                .sum_in   (sum_v[r][c]),
                .sum_out  (sum_v[r+1][c])
            );
        end
    end

    // ========================================
    // top edge and output deskew
    // ========================================
    for (genvar c = 0; c < ARR_N; c++) begin : g_edge
        assign w_v[0][c]   = w_in[c*DATA_W +: DATA_W];
        assign sum_v[0][c] = '0;                        // no bias
        if (c == ARR_N - 1) begin : g_last
            assign result[c*ACC_W +: ACC_W] = sum_v[ARR_N][c]; // already latest
        end else begin : g_dsk
            localparam int DEPTH = ARR_N - 1 - c;
            acc_t dsk_q [DEPTH];
            always_ff @(posedge clk) begin
                dsk_q[0] <= sum_v[ARR_N][c];
                for (int k = 1; k < DEPTH; k++) begin
                    dsk_q[k] <= dsk_q[k-1];
                end
            end
            assign result[c*ACC_W +: ACC_W] = dsk_q[DEPTH-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[ARR_LAT-2:0], in_valid};
        end
    end

    assign result_valid = vld_q[ARR_LAT-1];

endmodule

// File: mac_cell.sv
/* one processing element; the weight only moves while w_shift is high
   and the product uses the weight held before the edge */
`timescale 1ns/1ns

module mac_cell import tpu_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  data_t data_in,      // from the left
    output data_t data_out,     // to the right, one cycle later
    input  data_t w_in,         // from the cell above
    output data_t w_out,        // to the cell below
    input  logic  w_shift,
    input  acc_t  sum_in,       // partial sum from above
    output acc_t  sum_out       // partial sum to below
);

    data_t w_q;                 // stationary weight

    always_ff @(posedge clk) begin
        if (rst) begin
            w_q      <= '0;
            data_out <= '0;
            sum_out  <= '0;
        end else begin
            if (w_shift) begin
                w_q <= w_in;    // weight column moves down
            end
            data_out <= data_in;
            sum_out  <= sum_in + acc_t'(data_in) * acc_t'(w_q); // full precision mac
        end
    end

    assign w_out = w_q;

endmodule

// File: tpu_pkg.sv
/* sizes, latencies and types shared by every block of the matrix engine
   the array is square with ARR_N lanes; all values are fixed here */
package tpu_pkg;

    // ========================================
    // sizes
    // ========================================
    localparam int ARR_N     = 4;                   // lanes, array is ARR_N x ARR_N
    localparam int DATA_W    = 8;                   // signed element
    localparam int ACC_W     = 24;                  // signed sum, wraps
    localparam int MEM_DEPTH = 16;                  // rows per memory bank
    localparam int ACC_DEPTH = 16;                  // result rows in the table
    localparam int MEM_AW    = $clog2(MEM_DEPTH);
    localparam int ACC_AW    = $clog2(ACC_DEPTH);
    localparam int CNT_W     = $clog2(MEM_DEPTH + 1); // holds 1..16

    // input skew, sum chain and output deskew
    localparam int ARR_LAT   = 2 * ARR_N - 1;

    // ========================================
    // types
    // ========================================
    typedef logic signed [DATA_W-1:0]       data_t;
    typedef logic signed [ACC_W-1:0]        acc_t;
    typedef logic [ARR_N*DATA_W-1:0]        data_vec_t;  // lane k at slice k
    typedef logic [ARR_N*ACC_W-1:0]         acc_vec_t;
    typedef logic [ARR_N-1:0]               lane_mask_t;
    typedef logic [MEM_AW-1:0]              mem_addr_t;
    typedef logic [ACC_AW-1:0]              acc_addr_t;
    typedef logic [CNT_W-1:0]               row_cnt_t;

    typedef enum logic [2:0] {
        IDLE,       // waiting for a command
        FILL,       // weight memory -> fifo
        DRAIN,      // fifo -> array
        STREAM,     // input rows into the array
        FLUSH       // waiting for the last results
    } ctrl_state_t;

endpackage
